/* files.f */
vga_pkg.sv
wb_pixel_port.sv
frame_buffer.sv
vga_timing.sv
vga_pixel_out.sv
vga_framebuffer_top.sv
tb_vga_framebuffer.sv

/* frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer import vga_pkg::*; (
	input  logic      clk,
	input  fb_host_t  host,
	output pixel_t    host_rdata,
	input  scan_pos_t scan,
	output pixel_t    scan_pixel,
	output scan_pos_t scan_info
);

	// One word per 4x4 screen block
	pixel_t mem [FB_DEPTH];

	logic [COORD_W-1:0]   col;
	logic [COORD_W-1:0]   row;
	logic [FB_ADDR_W-1:0] scan_addr;

	////////////////////////////////////////
	// Host port
	////////////////////////////////////////
	// Writes only inside the buffer, reads every clock
	always_ff @(posedge clk) begin
		if (host.we && host.in_range) begin
			mem[host.addr] <= host.wdata;
		end
		host_rdata <= mem[host.addr];
	end

	////////////////////////////////////////
	// Scan port
	////////////////////////////////////////
	// Screen position down to block position
	assign col = scan.x >> SCALE_SHIFT;
	assign row = scan.y >> SCALE_SHIFT;

	// Row-major word index
	assign scan_addr = FB_ADDR_W'(row) * FB_ADDR_W'(FB_W) + FB_ADDR_W'(col);

	// Position delayed with its word so both stay paired
	always_ff @(posedge clk) begin
		scan_pixel <= mem[scan_addr];
		scan_info  <= scan;
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f \
	--top-module tb_vga_framebuffer -o sim_tb

output="$(./obj_dir/sim_tb)"
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
	exit 0
else
	exit 1
fi

/* tb_vga_framebuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vga_framebuffer import vga_pkg::*; ();

	logic     M10k_pll;
	logic     reset;
	wb_req_t  wb_req;
	wb_rsp_t  wb_rsp;
	vga_out_t vga;

	int errors;
	int checks;
	// Last word written per address, for bus read back
	pixel_t model [FB_DEPTH];

	vga_framebuffer_top DUT (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.vga      (vga)
	);

	// 4 ns clock
	initial begin
		M10k_pll = 1'b0;
		forever #2 M10k_pll = ~M10k_pll;
	end

	// Fill and both frame checks fit in about two frames
	initial begin
		repeat (H_TOTAL * V_TOTAL * 22 / 10) @(posedge M10k_pll);
		$display("Watchdog timeout, the tests did not complete in time");
		$display("Finished with errors");
		$finish;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	// Drive and sample 1 ns past the edge
	task automatic next_cycle();
		@(posedge M10k_pll);
		#1;
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
		checks++;
		if (got !== exp) begin
			report_error($sformatf("%s got %h expected %h", what, got.raw, exp.raw));
		end
	endtask

	task automatic check_vga(input vga_out_t got, input vga_out_t exp, input string what);
		checks++;
		if (got !== exp) begin
			report_error($sformatf("%s got %h expected %h", what, got, exp));
		end
	endtask

	task automatic expect_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
		end
	endtask

	task automatic log_test(input string name, input int err_start);
		$display("Test %s %s with %0d errors", name,
			(errors == err_start) ? "passed" : "FAILED", errors - err_start);
	endtask

	// Mixes every index bit into the word
	function automatic pixel_t pattern_word(input int idx);
		pixel_t p;
		p.raw = 16'((idx * 40503) ^ (idx >> 9));
		return p;
	endfunction

	// RGB565 to 8-bit levels, low bits zero
	function automatic vga_out_t expand_pixel(input pixel_t p);
		vga_out_t v;
		v         = '0;
		v.red     = {p.rgb.red, 3'b000};
		v.green   = {p.rgb.green, 2'b00};
		v.blue    = {p.rgb.blue, 3'b000};
		v.blank_n = 1'b1;
		return v;
	endfunction

	////////////////////////////////////////
	// Wishbone master
	////////////////////////////////////////
	// One classic cycle, ack expected on the first edge
	task automatic bus_cycle(input logic we, input logic [FB_ADDR_W-1:0] adr,
			input pixel_t wdat, output pixel_t rdat);
		int waited;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		waited     = 0;
		do begin
			next_cycle();
			waited++;
		end while (!wb_rsp.ack && waited < 4);
		if (!wb_rsp.ack) begin
			errors++;
			$display("No ack from the Wishbone port within 4 clocks at %0t", $time);
		end else if (waited != 1) begin
			report_error($sformatf("ack came %0d clocks after the request", waited));
		end
		rdat = wb_rsp.dat;
		// Strobe drops the clock after ack
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
		next_cycle();
	endtask

	task automatic wb_write(input logic [FB_ADDR_W-1:0] adr, input pixel_t dat);
		pixel_t unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [FB_ADDR_W-1:0] adr, output pixel_t dat);
		bus_cycle(1'b0, adr, '0, dat);
	endtask

	// Returns on the first sample after the vsync pulse
	task automatic wait_vsync_end();
		logic prev;
		do begin
			prev = vga.vsync;
			next_cycle();
		end while (!(!prev && vga.vsync));
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	task automatic reset_state();
		int       err_start;
		vga_out_t idle;
		err_start  = errors;
		idle       = '0;
		idle.hsync = 1'b1;
		idle.vsync = 1'b1;
		check_vga(vga, idle, "Outputs after reset");
		expect_count("ack after reset", int'(wb_rsp.ack), 0);
		log_test("reset_state", err_start);
	endtask

	task automatic wishbone_access();
		int                   err_start;
		int                   i;
		logic [FB_ADDR_W-1:0] addrs [$];
		logic [FB_ADDR_W-1:0] a;
		pixel_t               d;
		pixel_t               got;
		err_start = errors;
		for (i = 0; i < 64; i++) begin
			a        = FB_ADDR_W'($urandom_range(FB_DEPTH - 1));
			d.raw    = 16'($urandom);
			model[a] = d;
			addrs.push_back(a);
			wb_write(a, d);
		end
		foreach (addrs[j]) begin
			wb_read(addrs[j], got);
			check_pixel(got, model[addrs[j]], $sformatf("Read back at %0d", addrs[j]));
		end
		// Past the last word, acked but not stored
		a     = FB_ADDR_W'(FB_DEPTH + $urandom_range((1 << FB_ADDR_W) - FB_DEPTH - 1));
		d.raw = 16'($urandom) | 16'h0001;
		wb_write(a, d);
		wb_read(a, got);
		check_pixel(got, '0, $sformatf("Out of range read at %0d", a));
		log_test("wishbone_access", err_start);
	endtask

	// First lines after reset, all of them active
	task automatic hsync_timing();
		int   err_start;
		int   cnt;
		int   last_fall;
		int   falls;
		int   low;
		int   high;
		logic prev;
		err_start = errors;
		cnt       = 0;
		last_fall = 0;
		falls     = 0;
		low       = 0;
		high      = 0;
		prev      = vga.hsync;
		while (falls < 4) begin
			next_cycle();
			cnt++;
			if (prev && !vga.hsync) begin
				if (falls > 0) begin
					expect_count("hsync period", cnt - last_fall, H_TOTAL);
					expect_count("blank_n high clocks per line", high, H_ACTIVE);
				end
				last_fall = cnt;
				falls++;
				low  = 0;
				high = 0;
			end
			if (!prev && vga.hsync && falls > 0) begin
				expect_count("hsync pulse width", low, H_PULSE);
			end
			if (!vga.hsync) low++;
			if (vga.blank_n) high++;
			prev = vga.hsync;
		end
		log_test("hsync_timing", err_start);
	endtask

	task automatic vsync_timing();
		int   err_start;
		int   c;
		int   low;
		int   lines;
		logic prev_bn;
		err_start = errors;
		low       = 0;
		lines     = 0;
		wait_vsync_end();
		prev_bn = vga.blank_n;
		for (c = 0; c < H_TOTAL * V_TOTAL; c++) begin
			if (!vga.vsync) low++;
			if (vga.blank_n && !prev_bn) lines++;
			prev_bn = vga.blank_n;
			next_cycle();
		end
		expect_count("vsync low clocks per frame", low, V_PULSE * H_TOTAL);
		expect_count("active lines per frame", lines, V_ACTIVE);
		log_test("vsync_timing", err_start);
	endtask

	// Window opens at the start of the vertical back porch
	task automatic picture_content();
		int       err_start;
		int       i;
		int       c;
		int       k;
		int       hpos;
		int       line;
		int       x;
		int       y;
		vga_out_t exp;
		err_start = errors;
		for (i = 0; i < FB_DEPTH; i++) begin
			wb_write(FB_ADDR_W'(i), pattern_word(i));
		end
		wait_vsync_end();
		k = 0;
		for (c = 0; c < H_TOTAL * V_TOTAL; c++) begin
			hpos = c % H_TOTAL;
			line = c / H_TOTAL;
			exp  = '0;
			if (hpos < H_ACTIVE && line >= V_BACK && line < V_BACK + V_ACTIVE) begin
				// k counts visible clocks in scan order
				x   = k % H_ACTIVE;
				y   = k / H_ACTIVE;
				exp = expand_pixel(pattern_word((y >> SCALE_SHIFT) * FB_W + (x >> SCALE_SHIFT)));
				k++;
			end
			exp.hsync = !(hpos >= H_ACTIVE + H_FRONT && hpos < H_ACTIVE + H_FRONT + H_PULSE);
			exp.vsync = (line < V_TOTAL - V_PULSE);
			check_vga(vga, exp, $sformatf("Frame clock %0d", c));
			next_cycle();
		end
		log_test("picture_content", err_start);
	endtask

	////////////////////////////////////////
	// Sequence
	////////////////////////////////////////
	initial begin
		void'($urandom(32'h95d9_824c));
		errors = 0;
		checks = 0;
		reset  = 1'b1;
		wb_req = '0;
		repeat (3) next_cycle();
		reset = 1'b0;
		reset_state();
		wishbone_access();
		hsync_timing();
		// Both watch the same frame after the fill
		fork
			vsync_timing();
			picture_content();
		join
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vga_framebuffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_framebuffer_top import vga_pkg::*; (
	input  logic     M10k_pll,
	input  logic     reset,
	input  wb_req_t  wb_req,
	output wb_rsp_t  wb_rsp,
	output vga_out_t vga
);

	// Host side
	fb_host_t  host;
	pixel_t    host_rdata;

	// Scan side
	scan_pos_t scan;
	scan_pos_t scan_info;
	pixel_t    scan_pixel;
	logic      hsync_raw;
	logic      vsync_raw;

	////////////////////////////////////////
	// Bus to buffer
	////////////////////////////////////////
	wb_pixel_port u_wb_pixel_port (
		.clk        (M10k_pll),
		.reset      (reset),
		.req        (wb_req),
		.rsp        (wb_rsp),
		.host       (host),
		.host_rdata (host_rdata)
	);

	frame_buffer u_frame_buffer (
		.clk        (M10k_pll),
		.host       (host),
		.host_rdata (host_rdata),
		.scan       (scan),
		.scan_pixel (scan_pixel),
		.scan_info  (scan_info)
	);

	////////////////////////////////////////
	// Buffer to screen
	////////////////////////////////////////
	vga_timing u_vga_timing (
		.clk       (M10k_pll),
		.reset     (reset),
		.scan      (scan),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw)
	);

	// Two clocks from scan position to pins
	vga_pixel_out u_vga_pixel_out (
		.clk       (M10k_pll),
		.reset     (reset),
		.pixel     (scan_pixel),
		.scan_info (scan_info),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw),
		.vga       (vga)
	);

endmodule

`default_nettype wire

/* vga_pixel_out.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_pixel_out import vga_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  pixel_t    pixel,
	input  scan_pos_t scan_info,
	input  logic      hsync_raw,
	input  logic      vsync_raw,
	output vga_out_t  vga
);

	logic     hsync_d;
	logic     vsync_d;
	vga_out_t vga_next;

	// Syncs wait one clock for the buffer read
	always_ff @(posedge clk) begin
		if (reset) begin
			hsync_d <= 1'b1;
			vsync_d <= 1'b1;
		end else begin
			hsync_d <= hsync_raw;
			vsync_d <= vsync_raw;
		end
	end

	////////////////////////////////////////
	// Colour expansion
	////////////////////////////////////////
	always_comb begin
		vga_next = VGA_OUT_IDLE;
		// Low bits padded with zeros
		if (scan_info.active) begin
			vga_next.red   = {pixel.rgb.red, 3'b000};
			vga_next.green = {pixel.rgb.green, 2'b00};
			vga_next.blue  = {pixel.rgb.blue, 3'b000};
		end
		vga_next.hsync   = hsync_d;
		vga_next.vsync   = vsync_d;
		// True active region, not the sync AND
		vga_next.blank_n = scan_info.active;
	end

	// Pins come straight from flops
	always_ff @(posedge clk) begin
		if (reset) begin
			vga <= VGA_OUT_IDLE;
		end else begin
			vga <= vga_next;
		end
	end

endmodule

`default_nettype wire

/* vga_pkg.sv */
`default_nettype none

package vga_pkg;

	////////////////////////////////////////
	// Horizontal timing in pixel clocks
	////////////////////////////////////////
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_PULSE  = 96;
	localparam int H_BACK   = 48;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_PULSE + H_BACK;

	////////////////////////////////////////
	// Vertical timing in lines
	////////////////////////////////////////
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_PULSE  = 2;
	localparam int V_BACK   = 33;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_PULSE + V_BACK;

	// Segment codes, same order for both porch machines
	localparam logic [1:0] SEG_ACTIVE = 2'd0;
	localparam logic [1:0] SEG_FRONT  = 2'd1;
	localparam logic [1:0] SEG_PULSE  = 2'd2;
	localparam logic [1:0] SEG_BACK   = 2'd3;

	////////////////////////////////////////
	// Screen and buffer geometry
	////////////////////////////////////////
	localparam int COORD_W     = 10;
	// Each stored pixel covers a 4x4 screen block
	localparam int SCALE_SHIFT = 2;
	localparam int FB_W        = H_ACTIVE >> SCALE_SHIFT;
	localparam int FB_H        = V_ACTIVE >> SCALE_SHIFT;
	localparam int FB_DEPTH    = FB_W * FB_H;
	localparam int FB_ADDR_W   = 15;

	// Scan position as seen by the buffer read side
	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
		logic               active;
	} scan_pos_t;

	// RGB565 fields, red in the top bits
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// Bus side sees the raw word, colour stage sees fields
	typedef union packed {
		logic [15:0] raw;
		rgb565_t     rgb;
	} pixel_t;

	// VGA pins
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
		logic       hsync;
		logic       vsync;
		logic       blank_n;
	} vga_out_t;

	// Idle level of the pins, syncs high and picture dark
	localparam vga_out_t VGA_OUT_IDLE = '{
		red: 8'h00, green: 8'h00, blue: 8'h00,
		hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0
	};

	// Wishbone classic master to slave
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [FB_ADDR_W-1:0] adr;
		pixel_t               dat;
	} wb_req_t;

	// Wishbone classic slave to master
	typedef struct packed {
		logic   ack;
		pixel_t dat;
	} wb_rsp_t;

	// Host port of the frame buffer
	typedef struct packed {
		logic                 we;
		logic                 in_range;
		logic [FB_ADDR_W-1:0] addr;
		pixel_t               wdata;
	} fb_host_t;

endpackage

`default_nettype wire

/* vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing import vga_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	output scan_pos_t scan,
	output logic      hsync_raw,
	output logic      vsync_raw
);

	logic [1:0]         h_state;
	logic [1:0]         v_state;
	logic [COORD_W-1:0] h_count;
	logic [COORD_W-1:0] v_count;
	logic [COORD_W-1:0] h_len;
	logic [COORD_W-1:0] v_len;
	logic               h_last;
	logic               v_last;
	logic               line_end;

	// Length of the current horizontal segment
	always_comb begin
		case (h_state)
			SEG_ACTIVE: h_len = COORD_W'(H_ACTIVE);
			SEG_FRONT:  h_len = COORD_W'(H_FRONT);
			SEG_PULSE:  h_len = COORD_W'(H_PULSE);
			default:    h_len = COORD_W'(H_BACK);
		endcase
	end

	// Length of the current vertical segment
	always_comb begin
		case (v_state)
			SEG_ACTIVE: v_len = COORD_W'(V_ACTIVE);
			SEG_FRONT:  v_len = COORD_W'(V_FRONT);
			SEG_PULSE:  v_len = COORD_W'(V_PULSE);
			default:    v_len = COORD_W'(V_BACK);
		endcase
	end

	assign h_last   = (h_count == h_len - 1'b1);
	assign v_last   = (v_count == v_len - 1'b1);
	// Last back porch clock closes the line
	assign line_end = (h_state == SEG_BACK) && h_last;

	////////////////////////////////////////
	// Horizontal machine
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			h_state <= SEG_ACTIVE;
			h_count <= '0;
		end else if (h_last) begin
			// Segments follow in code order and wrap to active
			h_state <= h_state + 2'd1;
			h_count <= '0;
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	////////////////////////////////////////
	// Vertical machine
	////////////////////////////////////////
	// Steps once per line, same edge the line wraps
	always_ff @(posedge clk) begin
		if (reset) begin
			v_state <= SEG_ACTIVE;
			v_count <= '0;
		end else if (line_end) begin
			if (v_last) begin
				v_state <= v_state + 2'd1;
				v_count <= '0;
			end else begin
				v_count <= v_count + 1'b1;
			end
		end
	end

	// Position of the pixel wanted now, zero outside active
	always_comb begin
		scan.x      = (h_state == SEG_ACTIVE) ? h_count : '0;
		scan.y      = (v_state == SEG_ACTIVE) ? v_count : '0;
		scan.active = (h_state == SEG_ACTIVE) && (v_state == SEG_ACTIVE);
	end

	// Syncs are active low, only in the pulse segment
	assign hsync_raw = (h_state != SEG_PULSE);
	assign vsync_raw = (v_state != SEG_PULSE);

	// Counters never run past their segment
	a_h_count_range : assert property (
		@(posedge clk) disable iff (reset) h_count < h_len
	);
	a_v_count_range : assert property (
		@(posedge clk) disable iff (reset) v_count < v_len
	);

endmodule

`default_nettype wire

/* wb_pixel_port.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_pixel_port import vga_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  wb_req_t  req,
	output wb_rsp_t  rsp,
	output fb_host_t host,
	input  pixel_t   host_rdata
);

	logic ack;
	logic start;
	logic in_range;
	logic range_q;

	// New cycle only while no ack is outstanding
	assign start    = req.cyc && req.stb && !ack;
	// Words past the last buffer row are ignored
	assign in_range = (req.adr < FB_ADDR_W'(FB_DEPTH));

	// Buffer access straight from the bus
	always_comb begin
		host.we       = start && req.we;
		host.in_range = in_range;
		host.addr     = req.adr;
		host.wdata    = req.dat;
	end

	// One-clock ack, write lands on the same edge
	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
		end else begin
			ack <= start;
		end
	end

	// Range flag travels with the read data
	always_ff @(posedge clk) begin
		range_q <= in_range;
	end

	// Read data valid during ack, zero when out of range
	always_comb begin
		rsp.ack = ack;
		rsp.dat = range_q ? host_rdata : pixel_t'('0);
	end

	// Every ack answers a request seen one clock earlier
	a_ack_after_req : assert property (
		@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(req.cyc && req.stb)
	);

endmodule

`default_nettype wire
